// File: list.f
alert_handler_pkg.sv
alert_handler_esc_pkg.sv
alert_handler_class.sv
alert_handler_accu.sv
alert_handler_esc_timer.sv
alert_handler.sv
alert_handler_sva.sv
tb_alert_handler.sv

// File: Bender.yml
package:
  name: alert_handler

sources:
  # Design, in compile order
  - files:
      - alert_handler_pkg.sv
      - alert_handler_esc_pkg.sv
      - alert_handler_class.sv
      - alert_handler_accu.sv
      - alert_handler_esc_timer.sv
      - alert_handler.sv

  # Verification
  - target: test
    files:
      - alert_handler_sva.sv
      - tb_alert_handler.sv

// File: tb_alert_handler.sv
// Random-stimulus testbench for the alert handler
// A cycle-based model predicts all outputs, compared on every falling edge
// Class configuration only changes together with a clear of that class

module tb_alert_handler;

  logic                                                                     clk_i;
  logic                                                                     rst_n_i;
  alert_handler_pkg::alert_vec_t                                            alert_i;
  alert_handler_pkg::alert_vec_t                                            alert_en_i;
  alert_handler_pkg::alert_vec_t                                            cause_clr_i;
  alert_handler_pkg::class_idx_t     [alert_handler_pkg::N_ALERTS-1:0]      alert_class_i;
  alert_handler_pkg::class_vec_t                                            class_en_i;
  alert_handler_pkg::class_vec_t                                            class_clr_i;
  alert_handler_pkg::accu_cnt_t      [alert_handler_pkg::N_CLASSES-1:0]     accu_thresh_i;
  alert_handler_esc_pkg::esc_cnt_t   [alert_handler_pkg::N_CLASSES-1:0]     timeout_cyc_i;
  alert_handler_esc_pkg::esc_cnt_t   [alert_handler_pkg::N_CLASSES-1:0]     phase_cyc_i;
  alert_handler_esc_pkg::sev_vec_t   [alert_handler_pkg::N_CLASSES-1:0]     class_esc_en_i;
  alert_handler_esc_pkg::phase_idx_t
    [alert_handler_pkg::N_CLASSES-1:0][alert_handler_esc_pkg::N_ESC_SEV-1:0] class_esc_map_i;
  alert_handler_pkg::class_vec_t                                            irq_o;
  alert_handler_pkg::alert_vec_t                                            cause_o;
  alert_handler_pkg::accu_cnt_t      [alert_handler_pkg::N_CLASSES-1:0]     accu_cnt_o;
  alert_handler_esc_pkg::esc_state_e [alert_handler_pkg::N_CLASSES-1:0]     state_o;
  alert_handler_esc_pkg::sev_vec_t                                          esc_o;

  // Reference model state
  alert_handler_pkg::alert_vec_t     m_cause;
  alert_handler_pkg::class_vec_t     m_irq;
  alert_handler_pkg::accu_cnt_t      m_cnt   [alert_handler_pkg::N_CLASSES];
  alert_handler_esc_pkg::esc_state_e m_state [alert_handler_pkg::N_CLASSES];
  alert_handler_esc_pkg::esc_cnt_t   m_tcnt  [alert_handler_pkg::N_CLASSES];

  integer seed;
  string  test_name;
  int     n;

  alert_handler dut_i (.*);

  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic int phase_num(alert_handler_esc_pkg::esc_state_e st);
    case (st)
      alert_handler_esc_pkg::PHASE0: return 0;
      alert_handler_esc_pkg::PHASE1: return 1;
      alert_handler_esc_pkg::PHASE2: return 2;
      alert_handler_esc_pkg::PHASE3: return 3;
      default:                       return -1;
    endcase
  endfunction

  function automatic alert_handler_esc_pkg::esc_state_e next_phase(int ph);
    case (ph)
      0:       return alert_handler_esc_pkg::PHASE1;
      1:       return alert_handler_esc_pkg::PHASE2;
      2:       return alert_handler_esc_pkg::PHASE3;
      default: return alert_handler_esc_pkg::TERMINAL;
    endcase
  endfunction

  // Cumulative severity, OR over all classes
  function automatic alert_handler_esc_pkg::sev_vec_t expected_esc();
    alert_handler_esc_pkg::sev_vec_t e;
    int ph;
    e = '0;
    for (int c = 0; c < alert_handler_pkg::N_CLASSES; c++) begin
      ph = phase_num(m_state[c]);
      for (int s = 0; s < alert_handler_esc_pkg::N_ESC_SEV; s++) begin
        if (class_esc_en_i[c][s] && (m_state[c] == alert_handler_esc_pkg::TERMINAL ||
            (ph >= 0 && ph >= int'(class_esc_map_i[c][s])))) begin
          e[s] = 1'b1;
        end
      end
    end
    return e;
  endfunction

  // One rising edge, using the inputs as sampled
  task automatic model_step();
    alert_handler_pkg::alert_vec_t fire;
    alert_handler_pkg::class_vec_t trig;
    logic                          accu_hit;
    fire = alert_i & alert_en_i;
    trig = '0;
    for (int k = 0; k < alert_handler_pkg::N_ALERTS; k++) begin
      if (fire[k] && class_en_i[alert_class_i[k]]) begin
        trig[alert_class_i[k]] = 1'b1;
      end
    end
    for (int c = 0; c < alert_handler_pkg::N_CLASSES; c++) begin
      accu_hit = trig[c] && (m_cnt[c] >= accu_thresh_i[c]);
      if (class_clr_i[c]) begin
        m_state[c] = alert_handler_esc_pkg::IDLE;
        m_tcnt[c]  = '0;
      end else if (m_state[c] == alert_handler_esc_pkg::IDLE) begin
        m_tcnt[c] = '0;
        if (accu_hit && class_esc_en_i[c] != '0) begin
          m_state[c] = alert_handler_esc_pkg::PHASE0;
        end else if (m_irq[c] && timeout_cyc_i[c] != '0) begin
          m_state[c] = alert_handler_esc_pkg::TIMEOUT;
        end
      end else if (m_state[c] == alert_handler_esc_pkg::TIMEOUT) begin
        if (accu_hit || m_tcnt[c] == timeout_cyc_i[c] - 1) begin
          m_state[c] = alert_handler_esc_pkg::PHASE0;
          m_tcnt[c]  = '0;
        end else if (!m_irq[c]) begin
          m_state[c] = alert_handler_esc_pkg::IDLE;
          m_tcnt[c]  = '0;
        end else begin
          m_tcnt[c] = m_tcnt[c] + 1'b1;
        end
      end else if (phase_num(m_state[c]) >= 0) begin
        if (m_tcnt[c] == phase_cyc_i[c]) begin
          m_state[c] = next_phase(phase_num(m_state[c]));
          m_tcnt[c]  = '0;
        end else begin
          m_tcnt[c] = m_tcnt[c] + 1'b1;
        end
      end
      if (class_clr_i[c]) begin
        m_cnt[c] = '0;
      end else if (trig[c] && m_cnt[c] != '1) begin
        m_cnt[c] = m_cnt[c] + 1'b1;
      end
    end
    m_cause = (m_cause & ~cause_clr_i) | fire;
    m_irq   = (m_irq & ~class_clr_i) | trig;
  endtask

  //////////////////////////////////////////////////
  // Checking and sequencing
  //////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAIL %s: %s expected 'h%0h actual 'h%0h", test_name, sig, exp, act);
    stop_on_error();
  endtask

  task automatic compare_outputs();
    assert (irq_o === m_irq) else report_mismatch("irq_o", m_irq, irq_o);
    assert (cause_o === m_cause) else report_mismatch("cause_o", m_cause, cause_o);
    for (int c = 0; c < alert_handler_pkg::N_CLASSES; c++) begin
      assert (accu_cnt_o[c] === m_cnt[c])
        else report_mismatch($sformatf("accu_cnt_o[%0d]", c), m_cnt[c], accu_cnt_o[c]);
      assert (state_o[c] === m_state[c])
        else report_mismatch($sformatf("state_o[%0d]", c), m_state[c], state_o[c]);
    end
    assert (esc_o === expected_esc()) else report_mismatch("esc_o", expected_esc(), esc_o);
    // Bound concurrent checks on the DUT
    assert (dut_i.u_sva.fail_cnt == 0)
      else begin
        $display("A concurrent assertion on the DUT failed during %s", test_name);
        stop_on_error();
      end
  endtask

  // Ends on a falling edge, where new inputs are driven
  task automatic run_cycle();
    @(posedge clk_i);
    model_step();
    @(negedge clk_i);
    compare_outputs();
  endtask

  task automatic wait_for_state(input int c, input alert_handler_esc_pkg::esc_state_e st,
                                input int max_cyc, output int cnt);
    cnt = 0;
    while (state_o[c] !== st) begin
      if (cnt >= max_cyc) begin
        $display("Timeout in %s: class %0d did not reach state %0d within %0d cycles",
                 test_name, c, st, max_cyc);
        stop_on_error();
      end else begin
        run_cycle();
        cnt++;
      end
    end
  endtask

  task automatic pulse_clear(input alert_handler_pkg::class_vec_t mask);
    class_clr_i = mask;
    run_cycle();
    class_clr_i = '0;
  endtask

  task automatic configure_class(input int c, input int th, input int tmo, input int ph,
                                 input logic [3:0] en, input logic [7:0] map);
    accu_thresh_i[c]   = alert_handler_pkg::accu_cnt_t'(th);
    timeout_cyc_i[c]   = alert_handler_esc_pkg::esc_cnt_t'(tmo);
    phase_cyc_i[c]     = alert_handler_esc_pkg::esc_cnt_t'(ph);
    class_esc_en_i[c]  = en;
    class_esc_map_i[c] = map;
    pulse_clear(alert_handler_pkg::class_vec_t'(1 << c));
  endtask

  initial begin
    seed            = 88;
    clk_i           = 1'b0;
    rst_n_i         = 1'b0;
    alert_i         = '0;
    alert_en_i      = '0;
    cause_clr_i     = '0;
    alert_class_i   = '0;
    class_en_i      = '0;
    class_clr_i     = '0;
    accu_thresh_i   = '1;
    timeout_cyc_i   = '0;
    phase_cyc_i     = '0;
    class_esc_en_i  = '0;
    class_esc_map_i = '0;
    m_cause         = '0;
    m_irq           = '0;
    for (int c = 0; c < alert_handler_pkg::N_CLASSES; c++) begin
      m_cnt[c]   = '0;
      m_state[c] = alert_handler_esc_pkg::IDLE;
      m_tcnt[c]  = '0;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i   = 1'b1;
    test_name = "reset";
    compare_outputs();

    // Alerts with every enable low
    test_name = "disabled";
    for (int i = 0; i < 20; i++) begin
      alert_i    = alert_handler_pkg::alert_vec_t'($random(seed));
      class_en_i = alert_handler_pkg::class_vec_t'($random(seed));
      run_cycle();
    end

    test_name = "classify";
    for (int i = 0; i < 200; i++) begin
      if (i % 25 == 0) begin
        for (int k = 0; k < alert_handler_pkg::N_ALERTS; k++) begin
          alert_class_i[k] = alert_handler_pkg::class_idx_t'($random(seed));
        end
      end
      alert_i     = alert_handler_pkg::alert_vec_t'($random(seed));
      alert_en_i  = alert_handler_pkg::alert_vec_t'($random(seed));
      class_en_i  = alert_handler_pkg::class_vec_t'($random(seed));
      cause_clr_i = alert_handler_pkg::alert_vec_t'($random(seed) & $random(seed));
      class_clr_i = (i % 9 == 0) ? alert_handler_pkg::class_vec_t'($random(seed)) : '0;
      run_cycle();
    end

    // Alert k belongs to class k mod 4 from here on
    alert_i     = '0;
    cause_clr_i = '0;
    class_clr_i = '0;
    alert_en_i  = '1;
    class_en_i  = '1;
    for (int k = 0; k < alert_handler_pkg::N_ALERTS; k++) begin
      alert_class_i[k] = alert_handler_pkg::class_idx_t'(k % alert_handler_pkg::N_CLASSES);
    end

    test_name = "threshold";
    configure_class(0, 3, 0, 2, 4'b1111, {2'd3, 2'd2, 2'd1, 2'd0});
    alert_i = 8'h11;
    wait_for_state(0, alert_handler_esc_pkg::PHASE0, 10, n);
    assert (n == 4) else report_mismatch("events to PHASE0", 4, n);
    alert_i = '0;
    wait_for_state(0, alert_handler_esc_pkg::TERMINAL, 20, n);
    assert (n == 12) else report_mismatch("cycles to TERMINAL", 12, n);
    repeat (3) run_cycle();
    pulse_clear(4'b0001);

    test_name = "timeout";
    configure_class(1, 200, 7, 1, 4'b0011, {2'd0, 2'd1, 2'd0, 2'd1});
    alert_i = 8'h02;
    run_cycle();
    alert_i = '0;
    wait_for_state(1, alert_handler_esc_pkg::PHASE0, 30, n);
    // One cycle of interrupt latency before the timeout starts
    assert (n == 8) else report_mismatch("cycles to PHASE0", 8, n);
    repeat (2) run_cycle();
    pulse_clear(4'b0010);
    alert_i = 8'h02;
    run_cycle();
    alert_i = '0;
    repeat (3) run_cycle();
    assert (state_o[1] === alert_handler_esc_pkg::TIMEOUT)
      else report_mismatch("state before clear", alert_handler_esc_pkg::TIMEOUT, state_o[1]);
    pulse_clear(4'b0010);
    wait_for_state(1, alert_handler_esc_pkg::IDLE, 2, n);

    test_name = "saturate";
    configure_class(2, 10, 0, 0, 4'b0000, 8'h00);
    alert_i = 8'h04;
    repeat (300) run_cycle();
    alert_i = '0;
    assert (accu_cnt_o[2] === 8'hff) else report_mismatch("saturated count", 255, accu_cnt_o[2]);
    pulse_clear(4'b0100);

    test_name = "multi";
    configure_class(0, 0, 0, 1, 4'b0101, {2'd3, 2'd1, 2'd0, 2'd2});
    configure_class(3, 1, 0, 2, 4'b1110, {2'd0, 2'd3, 2'd2, 2'd1});
    alert_i = 8'h99;
    repeat (2) run_cycle();
    for (int i = 0; i < 30; i++) begin
      alert_i = alert_handler_pkg::alert_vec_t'($random(seed)) & 8'h99;
      run_cycle();
    end
    alert_i = '0;
    wait_for_state(0, alert_handler_esc_pkg::TERMINAL, 40, n);
    wait_for_state(3, alert_handler_esc_pkg::TERMINAL, 40, n);
    pulse_clear(4'b1111);
    run_cycle();

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: alert_handler_sva.sv
// Concurrent checks on the alert handler top level
// Checks are disabled while reset is asserted

module alert_handler_sva (
  input logic                                                            clk_i,
  input logic                                                            rst_n_i,
  input alert_handler_pkg::alert_vec_t                                   alert_i,
  input alert_handler_pkg::alert_vec_t                                   alert_en_i,
  input alert_handler_pkg::class_idx_t [alert_handler_pkg::N_ALERTS-1:0] alert_class_i,
  input alert_handler_pkg::class_vec_t                                   class_en_i,
  input alert_handler_pkg::class_vec_t                                   class_clr_i,
  input alert_handler_pkg::class_vec_t                                   irq_o,
  input alert_handler_esc_pkg::esc_state_e [alert_handler_pkg::N_CLASSES-1:0] state_o,
  input alert_handler_esc_pkg::sev_vec_t                                 esc_o
);

  alert_handler_pkg::class_vec_t hit;
  logic                          quiet;
  // Failure count, read by the testbench
  int unsigned                   fail_cnt = 0;

  always_comb begin
    hit   = '0;
    quiet = 1'b1;
    for (int k = 0; k < alert_handler_pkg::N_ALERTS; k++) begin
      if (alert_i[k] && alert_en_i[k] && class_en_i[alert_class_i[k]]) begin
        hit[alert_class_i[k]] = 1'b1;
      end
    end
    // Only IDLE and TIMEOUT count as quiet
    for (int c = 0; c < alert_handler_pkg::N_CLASSES; c++) begin
      if (state_o[c] != alert_handler_esc_pkg::IDLE &&
          state_o[c] != alert_handler_esc_pkg::TIMEOUT) begin
        quiet = 1'b0;
      end
    end
  end

  for (genvar c = 0; c < alert_handler_pkg::N_CLASSES; c++) begin : gen_class
    assert property (@(posedge clk_i) disable iff (!rst_n_i) hit[c] |=> irq_o[c])
      else begin
        $error("Class %0d event did not raise its interrupt", c);
        fail_cnt++;
      end
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     class_clr_i[c] |=> state_o[c] == alert_handler_esc_pkg::IDLE)
      else begin
        $error("Class %0d not idle after a clear", c);
        fail_cnt++;
      end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) quiet |-> esc_o == '0)
    else begin
      $error("Severity output active while no class is escalating");
      fail_cnt++;
    end

endmodule

bind alert_handler alert_handler_sva u_sva (.*);

// File: alert_handler.sv
// Alert handler top level
// Configuration ports are quasi-static and may only change while the
// affected class is being cleared
// Severity outputs are the OR of the per-class escalation requests

module alert_handler (
  input  logic                                                       clk_i,
  input  logic                                                       rst_n_i,
  input  alert_handler_pkg::alert_vec_t                              alert_i,
  input  alert_handler_pkg::alert_vec_t                              alert_en_i,
  input  alert_handler_pkg::alert_vec_t                              cause_clr_i,
  input  alert_handler_pkg::class_idx_t  [alert_handler_pkg::N_ALERTS-1:0]  alert_class_i,
  input  alert_handler_pkg::class_vec_t                              class_en_i,
  input  alert_handler_pkg::class_vec_t                              class_clr_i,
  input  alert_handler_pkg::accu_cnt_t   [alert_handler_pkg::N_CLASSES-1:0] accu_thresh_i,
  input  alert_handler_esc_pkg::esc_cnt_t [alert_handler_pkg::N_CLASSES-1:0] timeout_cyc_i,
  input  alert_handler_esc_pkg::esc_cnt_t [alert_handler_pkg::N_CLASSES-1:0] phase_cyc_i,
  input  alert_handler_esc_pkg::sev_vec_t [alert_handler_pkg::N_CLASSES-1:0] class_esc_en_i,
  input  alert_handler_esc_pkg::phase_idx_t
         [alert_handler_pkg::N_CLASSES-1:0][alert_handler_esc_pkg::N_ESC_SEV-1:0] class_esc_map_i,
  output alert_handler_pkg::class_vec_t                              irq_o,
  output alert_handler_pkg::alert_vec_t                              cause_o,
  output alert_handler_pkg::accu_cnt_t   [alert_handler_pkg::N_CLASSES-1:0] accu_cnt_o,
  output alert_handler_esc_pkg::esc_state_e [alert_handler_pkg::N_CLASSES-1:0] state_o,
  output alert_handler_esc_pkg::sev_vec_t                            esc_o
);

  alert_handler_pkg::class_vec_t class_trig;
  alert_handler_pkg::class_vec_t irq;

  alert_handler_esc_pkg::sev_vec_t [alert_handler_pkg::N_CLASSES-1:0] class_esc_req;
  alert_handler_pkg::class_vec_t   [alert_handler_esc_pkg::N_ESC_SEV-1:0] esc_req_trsp;

  //////////////////////////////////////////////////
  // Classification
  //////////////////////////////////////////////////

  alert_handler_class u_class (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .alert_i       ( alert_i       ),
    .alert_en_i    ( alert_en_i    ),
    .cause_clr_i   ( cause_clr_i   ),
    .alert_class_i ( alert_class_i ),
    .class_en_i    ( class_en_i    ),
    .class_clr_i   ( class_clr_i   ),
    .class_trig_o  ( class_trig    ),
    .irq_o         ( irq           ),
    .cause_o       ( cause_o       )
  );

  assign irq_o = irq;

  //////////////////////////////////////////////////
  // Per-class accumulation and escalation
  //////////////////////////////////////////////////

  for (genvar c = 0; c < alert_handler_pkg::N_CLASSES; c++) begin : gen_classes
    logic accu_trig;

    alert_handler_accu u_accu (
      .clk_i        ( clk_i            ),
      .rst_n_i      ( rst_n_i          ),
      .clr_i        ( class_clr_i[c]   ),
      .class_trig_i ( class_trig[c]    ),
      .thresh_i     ( accu_thresh_i[c] ),
      .accu_cnt_o   ( accu_cnt_o[c]    ),
      .accu_trig_o  ( accu_trig        )
    );

    // A pending interrupt arms the timeout
    alert_handler_esc_timer u_esc_timer (
      .clk_i         ( clk_i              ),
      .rst_n_i       ( rst_n_i            ),
      .clr_i         ( class_clr_i[c]     ),
      .timeout_en_i  ( irq[c]             ),
      .accu_trig_i   ( accu_trig          ),
      .timeout_cyc_i ( timeout_cyc_i[c]   ),
      .phase_cyc_i   ( phase_cyc_i[c]     ),
      .esc_en_i      ( class_esc_en_i[c]  ),
      .esc_map_i     ( class_esc_map_i[c] ),
      .esc_sig_req_o ( class_esc_req[c]   ),
      .state_o       ( state_o[c]         )
    );
  end

  // Severity merge across classes
  for (genvar s = 0; s < alert_handler_esc_pkg::N_ESC_SEV; s++) begin : gen_sev
    for (genvar c = 0; c < alert_handler_pkg::N_CLASSES; c++) begin : gen_trsp
      assign esc_req_trsp[s][c] = class_esc_req[c][s];
    end
    assign esc_o[s] = |esc_req_trsp[s];
  end

endmodule

// File: alert_handler_esc_timer.sv
// Per-class escalation control
// One counter serves both the interrupt timeout and the phase durations
// Every phase lasts phase_cyc_i+1 cycles, and TERMINAL is left only by a clear
// Configuration is expected to stay stable while the class is not idle

module alert_handler_esc_timer (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  clr_i,
  input  logic                                  timeout_en_i,
  input  logic                                  accu_trig_i,
  input  alert_handler_esc_pkg::esc_cnt_t       timeout_cyc_i,
  input  alert_handler_esc_pkg::esc_cnt_t       phase_cyc_i,
  input  alert_handler_esc_pkg::sev_vec_t       esc_en_i,
  input  alert_handler_esc_pkg::phase_idx_t [alert_handler_esc_pkg::N_ESC_SEV-1:0] esc_map_i,
  output alert_handler_esc_pkg::sev_vec_t       esc_sig_req_o,
  output alert_handler_esc_pkg::esc_state_e     state_o
);

  alert_handler_esc_pkg::esc_state_e state_d, state_q;
  alert_handler_esc_pkg::esc_cnt_t   cnt_d, cnt_q;
  alert_handler_esc_pkg::esc_cnt_t   cnt_inc;
  alert_handler_esc_pkg::phase_idx_t phase_idx;
  logic                              timeout_done;
  logic                              phase_done;
  logic                              in_phase;
  logic                              terminal;

  assign cnt_inc      = alert_handler_esc_pkg::esc_cnt_t'(cnt_q + 1'b1);
  // Only evaluated in TIMEOUT, which needs a non-zero timeout to be entered
  assign timeout_done = (cnt_q >= alert_handler_esc_pkg::esc_cnt_t'(timeout_cyc_i - 1'b1));
  assign phase_done   = (cnt_q >= phase_cyc_i);

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;

    case (state_q)
      alert_handler_esc_pkg::IDLE: begin
        cnt_d = '0;
        if (accu_trig_i && |esc_en_i) begin
          state_d = alert_handler_esc_pkg::PHASE0;
        end else if (timeout_en_i && timeout_cyc_i != '0) begin
          state_d = alert_handler_esc_pkg::TIMEOUT;
        end
      end

      // Interrupt pending and waiting for software
      alert_handler_esc_pkg::TIMEOUT: begin
        if (accu_trig_i || timeout_done) begin
          state_d = alert_handler_esc_pkg::PHASE0;
          cnt_d   = '0;
        end else if (!timeout_en_i) begin
          state_d = alert_handler_esc_pkg::IDLE;
          cnt_d   = '0;
        end else begin
          cnt_d = cnt_inc;
        end
      end

      alert_handler_esc_pkg::PHASE0: begin
        cnt_d = phase_done ? '0 : cnt_inc;
        if (phase_done) begin
          state_d = alert_handler_esc_pkg::PHASE1;
        end
      end

      alert_handler_esc_pkg::PHASE1: begin
        cnt_d = phase_done ? '0 : cnt_inc;
        if (phase_done) begin
          state_d = alert_handler_esc_pkg::PHASE2;
        end
      end

      alert_handler_esc_pkg::PHASE2: begin
        cnt_d = phase_done ? '0 : cnt_inc;
        if (phase_done) begin
          state_d = alert_handler_esc_pkg::PHASE3;
        end
      end

      alert_handler_esc_pkg::PHASE3: begin
        cnt_d = phase_done ? '0 : cnt_inc;
        if (phase_done) begin
          state_d = alert_handler_esc_pkg::TERMINAL;
        end
      end

      alert_handler_esc_pkg::TERMINAL: begin
        cnt_d = '0;
      end

      // Unused encoding
      default: begin
        state_d = alert_handler_esc_pkg::IDLE;
        cnt_d   = '0;
      end
    endcase

    // Class clear overrides everything
    if (clr_i) begin
      state_d = alert_handler_esc_pkg::IDLE;
      cnt_d   = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= alert_handler_esc_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  //////////////////////////////////////////////////
  // Severity decode
  //////////////////////////////////////////////////

  always_comb begin
    in_phase  = 1'b1;
    phase_idx = '0;
    case (state_q)
      alert_handler_esc_pkg::PHASE0: phase_idx = alert_handler_esc_pkg::phase_idx_t'(0);
      alert_handler_esc_pkg::PHASE1: phase_idx = alert_handler_esc_pkg::phase_idx_t'(1);
      alert_handler_esc_pkg::PHASE2: phase_idx = alert_handler_esc_pkg::phase_idx_t'(2);
      alert_handler_esc_pkg::PHASE3: phase_idx = alert_handler_esc_pkg::phase_idx_t'(3);
      default:                       in_phase  = 1'b0;
    endcase
  end

  assign terminal = (state_q == alert_handler_esc_pkg::TERMINAL);

  // Cumulative, once a severity turns on it stays on until a clear
  always_comb begin
    for (int s = 0; s < alert_handler_esc_pkg::N_ESC_SEV; s++) begin
      esc_sig_req_o[s] = esc_en_i[s] & (terminal | (in_phase & (phase_idx >= esc_map_i[s])));
    end
  end

  assign state_o = state_q;

endmodule

// File: alert_handler_accu.sv
// Per-class accumulation counter
// Counts one per class event and holds at the maximum value
// The trigger fires on the event that arrives with the count already at the
// threshold, so escalation starts on event number thresh+1

module alert_handler_accu (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         clr_i,
  input  logic                         class_trig_i,
  input  alert_handler_pkg::accu_cnt_t thresh_i,
  output alert_handler_pkg::accu_cnt_t accu_cnt_o,
  output logic                         accu_trig_o
);

  alert_handler_pkg::accu_cnt_t cnt_q;
  logic                         cnt_sat;

  // All ones means saturated
  assign cnt_sat = &cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (class_trig_i && !cnt_sat) begin
      cnt_q <= alert_handler_pkg::accu_cnt_t'(cnt_q + 1'b1);
    end
  end

  // Compared against the registered count before this event
  assign accu_trig_o = class_trig_i & (cnt_q >= thresh_i);
  assign accu_cnt_o  = cnt_q;

endmodule

// File: alert_handler_class.sv
// Alert qualification, classification and sticky status bits
// Alerts are plain levels sampled on every clock edge
// Several alerts of one class in the same cycle give a single class event
// Clear pulses lose against a set in the same cycle

module alert_handler_class (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  input  alert_handler_pkg::alert_vec_t                             alert_i,
  input  alert_handler_pkg::alert_vec_t                             alert_en_i,
  input  alert_handler_pkg::alert_vec_t                             cause_clr_i,
  input  alert_handler_pkg::class_idx_t [alert_handler_pkg::N_ALERTS-1:0] alert_class_i,
  input  alert_handler_pkg::class_vec_t                             class_en_i,
  input  alert_handler_pkg::class_vec_t                             class_clr_i,
  output alert_handler_pkg::class_vec_t                             class_trig_o,
  output alert_handler_pkg::class_vec_t                             irq_o,
  output alert_handler_pkg::alert_vec_t                             cause_o
);

  alert_handler_pkg::alert_vec_t alert_fire;
  alert_handler_pkg::class_vec_t class_hit;
  alert_handler_pkg::class_vec_t class_trig;
  alert_handler_pkg::alert_vec_t cause_q;
  alert_handler_pkg::class_vec_t irq_q;

  //////////////////////////////////////////////////
  // Enable and classify
  //////////////////////////////////////////////////

  assign alert_fire = alert_i & alert_en_i;

  // OR of all fired alerts mapped to each class
  always_comb begin
    class_hit = '0;
    for (int c = 0; c < alert_handler_pkg::N_CLASSES; c++) begin
      for (int k = 0; k < alert_handler_pkg::N_ALERTS; k++) begin
        if (alert_fire[k] && alert_class_i[k] == alert_handler_pkg::class_idx_t'(c)) begin
          class_hit[c] = 1'b1;
        end
      end
    end
  end

  // Disabled classes raise no events
  assign class_trig = class_hit & class_en_i;

  //////////////////////////////////////////////////
  // Sticky cause and interrupt bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cause_q <= '0;
      irq_q   <= '0;
    end else begin
      cause_q <= (cause_q & ~cause_clr_i) | alert_fire;
      irq_q   <= (irq_q & ~class_clr_i) | class_trig;
    end
  end

  assign class_trig_o = class_trig;
  assign irq_o        = irq_q;
  assign cause_o      = cause_q;

endmodule

// File: alert_handler_esc_pkg.sv
// Escalation-side sizes, counter types and the escalation state encoding
// Phase numbers are binary encoded, so N_PHASES must be a power of two

package alert_handler_esc_pkg;

  // Severity outputs and escalation phases
  localparam int unsigned N_ESC_SEV = 4;
  localparam int unsigned N_PHASES  = 4;

  // Timeout and phase counter width
  localparam int unsigned ESC_CNT_W = 16;

  // One bit per severity output
  typedef logic [N_ESC_SEV-1:0] sev_vec_t;

  // Phase at which a severity output turns on
  typedef logic [$clog2(N_PHASES)-1:0] phase_idx_t;

  // Cycle count for timeout and phase durations
  typedef logic [ESC_CNT_W-1:0] esc_cnt_t;

  // Phases are consecutive, TERMINAL follows PHASE3
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    TIMEOUT  = 3'd1,
    PHASE0   = 3'd2,
    PHASE1   = 3'd3,
    PHASE2   = 3'd4,
    PHASE3   = 3'd5,
    TERMINAL = 3'd6
  } esc_state_e;

endpackage

// File: alert_handler_pkg.sv
// Alert-side sizes and vector types
// Class numbers are binary encoded, so N_CLASSES must be a power of two
// Counts are unsigned and saturate in the accumulator

package alert_handler_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Single-wire alert inputs
  localparam int unsigned N_ALERTS = 8;

  // Escalation classes
  localparam int unsigned N_CLASSES = 4;

  // Accumulation counter width
  localparam int unsigned ACCU_CNT_W = 8;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Class number of one alert
  typedef logic [$clog2(N_CLASSES)-1:0] class_idx_t;

  // One bit per alert
  typedef logic [N_ALERTS-1:0] alert_vec_t;

  // One bit per class
  typedef logic [N_CLASSES-1:0] class_vec_t;

  // Accumulated event count, also used for the threshold
  typedef logic [ACCU_CNT_W-1:0] accu_cnt_t;

endpackage
